//--- hdl/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010; // Word access only
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // R-type layout; the other formats share rs1, rs2, rd and funct3 positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_fields_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

    localparam xlen_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

//--- hdl/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t instr;
    } if_id_t;

    // Control word produced by decode
    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src_imm; // Second operand from imm instead of rs2
        branch_e   branch;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{
        alu_op:      ALU_ADD,
        alu_src_imm: 1'b0,
        branch:      BR_NONE,
        mem_read:    1'b0,
        mem_write:   1'b0,
        reg_write:   1'b0,
        rd:          '0
    };

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        ctrl_t ctrl;
        xlen_t rs1_value;
        xlen_t rs2_value;
        xlen_t imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
        xlen_t     alu_result; // Also the data address
        xlen_t     store_value;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_addr_t rd;
        xlen_t     wb_value;
    } mem_wb_t;

    // Data port request
    typedef struct packed {
        xlen_t addr;
        xlen_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- hdl/register_bank.sv
`timescale 1ns/100ps
`default_nettype none

module register_bank (
    input  wire                    clock,
    input  wire                    arst_n,
    input  wire                    we,
    input  wire cpu_isa_pkg::reg_addr_t waddr,
    input  wire cpu_isa_pkg::xlen_t     wdata,
    input  wire cpu_isa_pkg::reg_addr_t raddr1,
    input  wire cpu_isa_pkg::reg_addr_t raddr2,
    output cpu_isa_pkg::xlen_t     rdata1,
    output cpu_isa_pkg::xlen_t     rdata2
);
    import cpu_isa_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata; // x0 never written
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_isa_pkg::alu_op_e op,
    input  wire cpu_isa_pkg::xlen_t   a,
    input  wire cpu_isa_pkg::xlen_t   b,
    output cpu_isa_pkg::xlen_t   result,
    output logic                 equal
);
    import cpu_isa_pkg::*;

    logic less_signed;

    assign less_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {31'b0, less_signed};
            ALU_PASS_B: result = b;
            default:    result = '0; // Spare encoding
        endcase
    end

    // Branch comparator for BEQ and BNE
    assign equal = (a == b);

endmodule

`default_nettype wire

//--- hdl/fetch.sv
`timescale 1ns/100ps
`default_nettype none

module fetch #(
    parameter cpu_isa_pkg::xlen_t RESET_PC = '0
) (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      enable,
    input  wire                      redirect,
    input  wire cpu_isa_pkg::xlen_t  redirect_target,
    input  wire                      flush,
    output cpu_isa_pkg::xlen_t       rom_address,
    input  wire cpu_isa_pkg::xlen_t  rom_data,
    output cpu_pipe_pkg::if_id_t     if_id
);
    import cpu_isa_pkg::*;

    xlen_t pc;
    xlen_t pc_next;

    // Taken branch wins over sequential fetch
    assign pc_next = redirect ? redirect_target : pc + 32'd4;
    assign rom_address = pc;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (enable) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= '0;
        end else if (enable) begin
            if_id <= '{valid: !flush, pc: pc, instr: rom_data}; // Squash on flush
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire                          enable,
    input  wire                          flush,
    input  wire cpu_pipe_pkg::if_id_t    if_id,
    output cpu_isa_pkg::reg_addr_t       rs1_addr,
    output cpu_isa_pkg::reg_addr_t       rs2_addr,
    input  wire cpu_isa_pkg::xlen_t      rs1_value,
    input  wire cpu_isa_pkg::xlen_t      rs2_value,
    output cpu_pipe_pkg::id_ex_t         id_ex
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    xlen_t         instr;
    instr_fields_t fields;
    xlen_t         imm_i;
    xlen_t         imm_s;
    xlen_t         imm_b;
    xlen_t         imm_u;
    xlen_t         imm;
    ctrl_t         ctrl;
    logic          r_type_ok;

    assign instr = if_id.valid ? if_id.instr : NOP_INSTR; // Bubble decodes as NOP
    assign fields = instr;
    assign rs1_addr = fields.rs1;
    assign rs2_addr = fields.rs2;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // Only SUB may set funct7 bit 5
    assign r_type_ok = (fields.funct7 == F7_BASE) ||
                       (fields.funct7 == F7_SUB && fields.funct3 == F3_ADD_SUB);

    always_comb begin
        ctrl = CTRL_NOP;
        imm = imm_i;
        case (fields.opcode)
            OP: begin
                ctrl.reg_write = r_type_ok;
                ctrl.rd = fields.rd;
                case (fields.funct3)
                    F3_ADD_SUB: ctrl.alu_op = fields.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.reg_write = 1'b0; // Shifts, SLTU
                endcase
            end
            OP_IMM: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = (fields.funct3 == F3_ADD_SUB); // ADDI only
                ctrl.rd = fields.rd;
            end
            LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.rd = fields.rd;
                imm = imm_u;
            end
            LOAD: begin
                if (fields.funct3 == F3_LW) begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_read = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.rd = fields.rd;
                end
            end
            STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write = (fields.funct3 == F3_SW);
                imm = imm_s;
            end
            BRANCH: begin
                imm = imm_b;
                if (fields.funct3 == F3_BEQ) begin
                    ctrl.branch = BR_EQ;
                end else if (fields.funct3 == F3_BNE) begin
                    ctrl.branch = BR_NE;
                end
            end
            default: ctrl = CTRL_NOP;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (enable) begin
            id_ex <= '{
                valid:     if_id.valid && !flush,
                pc:        if_id.pc,
                ctrl:      ctrl,
                rs1_value: rs1_value,
                rs2_value: rs2_value,
                imm:       imm
            };
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        enable,
    input  wire cpu_pipe_pkg::id_ex_t  id_ex,
    output logic                       redirect,
    output logic                       flush,
    output cpu_isa_pkg::xlen_t         redirect_target,
    output cpu_pipe_pkg::ex_mem_t      ex_mem
);
    import cpu_isa_pkg::*;

    xlen_t operand_b;
    xlen_t alu_result;
    logic  equal;
    logic  taken;

    assign operand_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_value;

    alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (id_ex.rs1_value),
        .b      (operand_b),
        .result (alu_result),
        .equal  (equal)
    );

    always_comb begin
        case (id_ex.ctrl.branch)
            BR_EQ:   taken = id_ex.valid && equal;
            BR_NE:   taken = id_ex.valid && !equal;
            default: taken = 1'b0;
        endcase
    end

    // Resolved here, so the two younger slots get squashed
    assign redirect = taken;
    assign flush = taken;
    assign redirect_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (enable) begin
            ex_mem <= '{
                valid:       id_ex.valid,
                mem_read:    id_ex.ctrl.mem_read,
                mem_write:   id_ex.ctrl.mem_write,
                reg_write:   id_ex.ctrl.reg_write,
                rd:          id_ex.ctrl.rd,
                alu_result:  alu_result,
                store_value: id_ex.rs2_value
            };
        end
    end

endmodule

`default_nettype wire

//--- hdl/memory.sv
`timescale 1ns/100ps
`default_nettype none

module memory (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire                         enable,
    input  wire cpu_pipe_pkg::ex_mem_t  ex_mem,
    output cpu_pipe_pkg::dmem_req_t     dmem_req,
    input  wire cpu_isa_pkg::xlen_t     dmem_rdata,
    output cpu_pipe_pkg::mem_wb_t       mem_wb
);
    import cpu_isa_pkg::*;

    xlen_t wb_value;

    // No write from a bubble or while stalled
    assign dmem_req = '{
        addr:  ex_mem.alu_result,
        wdata: ex_mem.store_value,
        we:    ex_mem.valid && ex_mem.mem_write && enable
    };

    assign wb_value = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else if (enable) begin
            mem_wb <= '{
                valid:     ex_mem.valid,
                reg_write: ex_mem.reg_write,
                rd:        ex_mem.rd,
                wb_value:  wb_value
            };
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu #(
    parameter cpu_isa_pkg::xlen_t RESET_PC = '0
) (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      enable,    // Pipeline-wide stall when low
    output cpu_isa_pkg::xlen_t       rom_address,
    input  wire cpu_isa_pkg::xlen_t  rom_data,
    output cpu_pipe_pkg::dmem_req_t  dmem_req,
    input  wire cpu_isa_pkg::xlen_t  dmem_rdata
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_value;
    xlen_t     rs2_value;

    logic      redirect;
    logic      flush;
    xlen_t     redirect_target;
    logic      rf_we;

    // Writeback stage folded into the register bank port
    assign rf_we = enable && mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clock           (clock),
        .arst_n          (arst_n),
        .enable          (enable),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .flush           (flush),
        .rom_address     (rom_address),
        .rom_data        (rom_data),
        .if_id           (if_id)
    );

    decode u_decode (
        .clock     (clock),
        .arst_n    (arst_n),
        .enable    (enable),
        .flush     (flush),
        .if_id     (if_id),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .id_ex     (id_ex)
    );

    register_bank u_register_bank (
        .clock  (clock),
        .arst_n (arst_n),
        .we     (rf_we),
        .waddr  (mem_wb.rd),
        .wdata  (mem_wb.wb_value),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_value),
        .rdata2 (rs2_value)
    );

    execute u_execute (
        .clock           (clock),
        .arst_n          (arst_n),
        .enable          (enable),
        .id_ex           (id_ex),
        .redirect        (redirect),
        .flush           (flush),
        .redirect_target (redirect_target),
        .ex_mem          (ex_mem)
    );

    memory u_memory (
        .clock      (clock),
        .arst_n     (arst_n),
        .enable     (enable),
        .ex_mem     (ex_mem),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .mem_wb     (mem_wb)
    );

endmodule

`default_nettype wire

//--- test/cpu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_properties (
    input wire                          clock,
    input wire                          arst_n,
    input wire                          enable,
    input wire cpu_isa_pkg::xlen_t      rom_address,
    input wire cpu_pipe_pkg::dmem_req_t dmem_req
);
    int unsigned fail_count = 0; // Failed assertion attempts so far

    // Data writes only in enabled cycles out of reset
    we_gated: assert property (@(posedge clock) !(dmem_req.we && (!enable || !arst_n)))
        else begin
            fail_count++;
            $error("data write while stalled or in reset");
        end

    pc_aligned: assert property (@(posedge clock) rom_address[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("instruction address not word aligned");
        end

    // A stall freezes the PC
    pc_held: assert property (@(posedge clock) disable iff (!arst_n)
        !enable |=> $stable(rom_address))
        else begin
            fail_count++;
            $error("instruction address moved during a stall");
        end

endmodule

`default_nettype wire

//--- test/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam xlen_t RESET_PC     = 32'h0000_0080;
    localparam int    ROM_WORDS    = 128;
    localparam int    RAM_WORDS    = 256;
    localparam int    DRAIN_CYCLES = 8;

    logic        clock;
    logic        arst_n;
    logic        enable = 1'b1;
    xlen_t       rom_address;
    xlen_t       rom_data = NOP_INSTR;
    dmem_req_t   dmem_req;
    xlen_t       dmem_rdata = '0;

    xlen_t       rom [ROM_WORDS];
    xlen_t       ram [RAM_WORDS];
    xlen_t       ram_init [RAM_WORDS];
    xlen_t       exp_ram [RAM_WORDS];
    dmem_req_t   exp_stores [$];
    int          store_idx = 0;
    int          rom_len;
    xlen_t       halt_pc;
    string       test_name = "reset";
    bit          stall_mode = 1'b0;
    logic [31:0] lcg_state = 32'hc0ee175d;
    longint      cycles = 0;
    longint      cycle_limit;

    cpu #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clock       (clock),
        .arst_n      (arst_n),
        .enable      (enable),
        .rom_address (rom_address),
        .rom_data    (rom_data),
        .dmem_req    (dmem_req),
        .dmem_rdata  (dmem_rdata)
    );

    bind cpu cpu_properties u_properties (
        .clock       (clock),
        .arst_n      (arst_n),
        .enable      (enable),
        .rom_address (rom_address),
        .dmem_req    (dmem_req)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t fill_word(xlen_t addr);
        return 32'h1357_9bdf ^ (addr * 32'h9e37_79b9);
    endfunction

    function automatic xlen_t rom_word(xlen_t addr);
        if (addr < ROM_WORDS * 4) begin
            return rom[addr >> 2];
        end
        return NOP_INSTR; // Outside the ROM image
    endfunction

    function automatic xlen_t rtype(logic [6:0] funct7, logic [2:0] funct3,
                                    reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        return {funct7, rs2, rs1, funct3, rd, OP};
    endfunction

    function automatic xlen_t itype(opcode_e opcode, logic [2:0] funct3,
                                    reg_addr_t rd, reg_addr_t rs1, xlen_t imm);
        return {imm[11:0], rs1, funct3, rd, opcode};
    endfunction

    function automatic xlen_t addi(reg_addr_t rd, reg_addr_t rs1, xlen_t imm);
        return itype(OP_IMM, F3_ADD_SUB, rd, rs1, imm);
    endfunction

    function automatic xlen_t lw(reg_addr_t rd, reg_addr_t rs1, xlen_t imm);
        return itype(LOAD, F3_LW, rd, rs1, imm);
    endfunction

    function automatic xlen_t sw(reg_addr_t rs2, reg_addr_t rs1, xlen_t imm);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], STORE};
    endfunction

    function automatic xlen_t lui(reg_addr_t rd, xlen_t value);
        return {value[31:12], rd, LUI};
    endfunction

    function automatic xlen_t cond_branch(logic [2:0] funct3, reg_addr_t rs1,
                                          reg_addr_t rs2, xlen_t off);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic void emit(xlen_t instr);
        rom[(RESET_PC >> 2) + rom_len] = instr;
        rom_len++;
    endfunction

    // Consumers sit at least three slots after their producers
    function automatic void load_program(int which);
        rom_len = 0;
        foreach (rom[i]) begin
            rom[i] = NOP_INSTR;
        end
        foreach (ram_init[i]) begin
            ram_init[i] = fill_word(xlen_t'(i * 4));
        end
        case (which)
            0: begin
                test_name = "alu";
                emit(lui(1, 32'h8000_1000));
                emit(addi(2, 0, 32'h5a5));
                emit(addi(3, 0, -7));
                emit(addi(1, 1, 32'h234));
                emit(addi(10, 0, 32'h40));
                emit(lui(12, 32'hfedc_b000));
                emit(rtype(F7_BASE, F3_ADD_SUB, 4, 1, 2));
                emit(rtype(F7_SUB, F3_ADD_SUB, 5, 1, 3));
                emit(rtype(F7_BASE, F3_AND, 6, 1, 2));
                emit(rtype(F7_BASE, F3_OR, 7, 1, 3));
                emit(rtype(F7_BASE, F3_XOR, 8, 2, 3));
                emit(rtype(F7_BASE, F3_SLT, 9, 1, 2));  // Negative below positive
                emit(rtype(F7_BASE, F3_SLT, 11, 2, 3));
                emit(sw(4, 10, 0));
                emit(sw(5, 10, 4));
                emit(sw(6, 10, 8));
                emit(sw(7, 10, 12));
                emit(sw(8, 10, 16));
                emit(sw(9, 10, 20));
                emit(sw(11, 10, 24));
                emit(addi(13, 3, 100));
                emit(sw(12, 10, 28));
                emit(sw(1, 10, 32));
                emit(sw(13, 10, 36));
            end
            1: begin
                test_name = "loads";
                emit(addi(10, 0, 32'h80));
                emit(NOP_INSTR);
                emit(NOP_INSTR);
                emit(lw(1, 10, 0));
                emit(lw(2, 10, 4));
                emit(lw(3, 10, -4));
                emit(NOP_INSTR);
                emit(rtype(F7_BASE, F3_ADD_SUB, 4, 1, 2));
                emit(rtype(F7_BASE, F3_XOR, 5, 2, 3));
                emit(rtype(F7_SUB, F3_ADD_SUB, 6, 3, 1));
                emit(sw(4, 10, 12));
                emit(sw(5, 10, 0));
                emit(sw(6, 10, 16));
                emit(lw(7, 10, 0));                     // Reads back a stored word
                emit(NOP_INSTR);
                emit(NOP_INSTR);
                emit(addi(8, 7, 1));
                emit(NOP_INSTR);
                emit(NOP_INSTR);
                emit(sw(8, 10, 20));
            end
            default: begin
                test_name = "branches";
                emit(addi(1, 0, 5));
                emit(addi(2, 0, 5));
                emit(addi(3, 0, 9));
                emit(addi(10, 0, 32'hc0));
                emit(addi(4, 0, 32'h11));
                emit(addi(5, 0, 32'h22));
                emit(cond_branch(F3_BEQ, 1, 2, 12));    // Taken
                emit(sw(4, 10, 0));
                emit(sw(5, 10, 4));
                emit(cond_branch(F3_BEQ, 1, 3, 12));    // Not taken
                emit(sw(4, 10, 8));
                emit(sw(5, 10, 12));
                emit(cond_branch(F3_BNE, 1, 3, 12));    // Taken
                emit(sw(4, 10, 16));
                emit(sw(5, 10, 20));
                emit(cond_branch(F3_BNE, 1, 2, 12));    // Not taken
                emit(sw(4, 10, 24));
                emit(sw(5, 10, 28));
                emit(cond_branch(F3_BNE, 3, 0, 8));     // Target is also a shadow slot
                emit(sw(4, 10, 32));
                emit(sw(3, 10, 36));
            end
        endcase
        halt_pc = RESET_PC + 4 * rom_len;
        emit(cond_branch(F3_BEQ, 0, 0, 0));
    endfunction

    // ISA-level run of the loaded program; returns the dynamic instruction count
    function automatic int run_model();
        xlen_t         regs [32];
        xlen_t         pc;
        xlen_t         next_pc;
        xlen_t         instr;
        xlen_t         a;
        xlen_t         b;
        xlen_t         addr;
        instr_fields_t f;
        int            count;
        exp_stores.delete();
        exp_ram = ram_init;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = RESET_PC;
        count = 0;
        while (pc != halt_pc && count < 1000) begin
            instr = rom_word(pc);
            f = instr;
            a = regs[f.rs1];
            b = regs[f.rs2];
            next_pc = pc + 4;
            case (f.opcode)
                OP: begin
                    case (f.funct3)
                        F3_ADD_SUB: regs[f.rd] = f.funct7[5] ? a - b : a + b;
                        F3_SLT:     regs[f.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F3_XOR:     regs[f.rd] = a ^ b;
                        F3_OR:      regs[f.rd] = a | b;
                        F3_AND:     regs[f.rd] = a & b;
                        default:    ;
                    endcase
                end
                OP_IMM: regs[f.rd] = a + {{20{instr[31]}}, instr[31:20]};
                LUI:    regs[f.rd] = {instr[31:12], 12'b0};
                LOAD: begin
                    addr = a + {{20{instr[31]}}, instr[31:20]};
                    regs[f.rd] = exp_ram[addr[9:2]];
                end
                STORE: begin
                    addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    exp_ram[addr[9:2]] = b;
                    exp_stores.push_back('{addr: addr, wdata: b, we: 1'b1});
                end
                BRANCH: begin
                    if ((f.funct3 == F3_BEQ) ? (a == b) : (a != b)) begin
                        next_pc = pc + {{19{instr[31]}}, instr[31], instr[7],
                                        instr[30:25], instr[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            regs[0] = '0;
            pc = next_pc;
            count++;
        end
        return count + 1; // Halt counts too
    endfunction

    task automatic stop_with_error(string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_store(dmem_req_t expected, dmem_req_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch in %s: store expected %h <= %h, actual %h <= %h",
                test_name, expected.addr, expected.wdata, actual.addr, actual.wdata));
        end
    endtask

    task automatic check_word(xlen_t addr, xlen_t expected, xlen_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch in %s: RAM word %h expected %h actual %h",
                test_name, addr, expected, actual));
        end
    endtask

    task automatic check_pc(xlen_t expected, xlen_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch in %s: rom_address expected %h actual %h",
                test_name, expected, actual));
        end
    endtask

    // Memory responses and stall pattern change on the falling edge
    always @(negedge clock) begin : drive_inputs
        logic [31:0] rnd;
        rnd = lcg_next();
        enable = stall_mode ? (rnd[31:30] != 2'b00) : 1'b1;
        rom_data = rom_word(rom_address);
        dmem_rdata = ram[dmem_req.addr[9:2]];
    end

    always @(posedge clock) begin
        if (!arst_n) begin
            ram <= ram_init;
        end else if (dmem_req.we) begin
            ram[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    // Store trace compare
    always @(posedge clock) begin
        if (!arst_n) begin
            store_idx <= 0;
        end else if (dmem_req.we) begin
            if (store_idx >= exp_stores.size()) begin
                stop_with_error($sformatf("unexpected store to %h of %h in %s",
                    dmem_req.addr, dmem_req.wdata, test_name));
            end else begin
                check_store(exp_stores[store_idx], dmem_req);
                store_idx <= store_idx + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            stop_with_error($sformatf("timeout after %0d cycles in %s", cycles, test_name));
        end else if (uut.u_properties.fail_count != 0) begin
            stop_with_error($sformatf("bound assertion failed in %s", test_name));
        end
    end

    task automatic run_program(int which, bit stall);
        int halt_fetches;
        int drained;
        @(negedge clock);
        arst_n = 1'b0;
        stall_mode = stall;
        load_program(which);
        if (stall) begin
            test_name = {test_name, " with stalls"};
        end
        void'(run_model());
        repeat (4) @(negedge clock);
        check_pc(RESET_PC, rom_address);
        arst_n = 1'b1;
        // Second fetch of the halt means every older store has retired
        halt_fetches = 0;
        while (halt_fetches < 2) begin
            @(posedge clock);
            if (enable && rom_address == halt_pc) begin
                halt_fetches++;
            end
        end
        drained = 0;
        while (drained < DRAIN_CYCLES) begin
            @(posedge clock);
            if (enable) begin
                drained++;
            end
        end
        @(negedge clock);
        if (store_idx != exp_stores.size()) begin
            stop_with_error($sformatf("%s: only %0d of %0d stores seen",
                test_name, store_idx, exp_stores.size()));
        end else begin
            foreach (ram[i]) begin
                check_word(xlen_t'(i * 4), exp_ram[i], ram[i]);
            end
        end
    endtask

    initial begin
        arst_n = 1'b0;
        cycle_limit = 200;
        for (int p = 0; p < 3; p++) begin
            load_program(p);
            cycle_limit += 2 * 4 * run_model(); // Each program also reruns with stalls
        end
        for (int round = 0; round < 2; round++) begin
            for (int p = 0; p < 3; p++) begin
                run_program(p, round == 1);
            end
        end
        if (uut.u_properties.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_error("bound assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- project.f
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/register_bank.sv
hdl/alu.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/cpu.sv
test/cpu_properties.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: rv32i_pipeline

sources:
  - hdl/cpu_isa_pkg.sv
  - hdl/cpu_pipe_pkg.sv
  - hdl/register_bank.sv
  - hdl/alu.sv
  - hdl/fetch.sv
  - hdl/decode.sv
  - hdl/execute.sv
  - hdl/memory.sv
  - hdl/cpu.sv
  - target: test
    files:
      - test/cpu_properties.sv
      - test/cpu_tb.sv
